// File: hw/d_rrag_settings.svh
`ifndef D_RRAG_SETTINGS_SVH
`define D_RRAG_SETTINGS_SVH

// number of queue entries between D and RrAg
`define D_RRAG_Q_LENGTH 8

// age tag width
// at least one bit wider than log2 of the depth so ages stay unambiguous
`define D_RRAG_TAG_WIDTH 4

// fixed micro-op payload, stands in for the decoded fields
`define D_RRAG_PAYLOAD_WIDTH 32

`endif

// File: hw/d_rrag_pkg.sv
`default_nettype none

`include "d_rrag_settings.svh"

package d_rrag_pkg;

    // age tag, assigned in sequence by the producer, wraps modulo 2**width
    typedef logic [`D_RRAG_TAG_WIDTH-1:0] tag_t;

    // fixed n-part of a queue entry
    typedef logic [`D_RRAG_PAYLOAD_WIDTH-1:0] payload_t;

    // modifiable m-part, valid bit on top, tag below
    typedef logic [`D_RRAG_TAG_WIDTH:0] m_field_t;

    // head and tail index into the queue
    typedef logic [$clog2(`D_RRAG_Q_LENGTH)-1:0] q_ptr_t;

    // occupancy, 0 up to and including the depth
    typedef logic [$clog2(`D_RRAG_Q_LENGTH+1)-1:0] q_count_t;

    // output register of the drain stage
    typedef enum logic {
        DRAIN_EMPTY,
        DRAIN_HOLD
    } drain_state_t;

endpackage

`default_nettype wire

// File: hw/queue_nm.sv
`timescale 1ns/1ns
`default_nettype none

`include "d_rrag_settings.svh"

// circular queue of micro-ops
// each entry is a modifiable m-part and a fixed n-part
// m-parts can be rewritten in place through a per-slot modify mask
module queue_nm
    import d_rrag_pkg::*;
#(
    parameter int M_WIDTH  = `D_RRAG_TAG_WIDTH + 1,
    parameter int N_WIDTH  = `D_RRAG_PAYLOAD_WIDTH,
    parameter int Q_LENGTH = `D_RRAG_Q_LENGTH
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [M_WIDTH-1:0]          m_din,
    input  logic [N_WIDTH-1:0]          n_din,
    input  logic [M_WIDTH*Q_LENGTH-1:0] new_m_vector,
    input  logic [Q_LENGTH-1:0]         modify_vector,
    input  logic                        wr,
    input  logic                        rd,
    input  logic                        clr,
    output logic                        full,
    output logic                        empty,
    output logic [M_WIDTH*Q_LENGTH-1:0] old_m_vector,
    output logic [M_WIDTH+N_WIDTH-1:0]  dout
);

    // entry storage, indexed by physical slot
    logic [M_WIDTH-1:0] m_mem [Q_LENGTH];
    logic [N_WIDTH-1:0] n_mem [Q_LENGTH];

    // control state
    q_ptr_t   head;
    q_ptr_t   tail;
    q_count_t count;

    // accepted operations this cycle
    logic do_wr;
    logic do_rd;

    // head m-part after bypass
    logic [M_WIDTH-1:0] head_m;

    // pointer increment with wrap at the depth
    function automatic q_ptr_t next_ptr(input q_ptr_t ptr);
        if (ptr == q_ptr_t'(Q_LENGTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // clear wins over both write and read
    // a write while full is dropped, a read while empty too
    assign do_wr = wr && !full && !clr;
    assign do_rd = rd && !empty && !clr;

    // status straight from the count
    assign full  = (count == q_count_t'(Q_LENGTH));
    assign empty = (count == '0);

    // pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (clr) begin
            // flush, old contents become unreachable
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                tail <= next_ptr(tail);
            end
            if (do_rd) begin
                head <= next_ptr(head);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry contents
    // masked m-part rewrite first, so a same-cycle write to a slot wins
    always_ff @(posedge clk) begin
        for (int i = 0; i < Q_LENGTH; i++) begin
            if (modify_vector[i]) begin
                m_mem[i] <= new_m_vector[i*M_WIDTH +: M_WIDTH];
            end
        end
        if (do_wr) begin
            m_mem[tail] <= m_din;
            n_mem[tail] <= n_din;
        end
    end

    // all m-parts flattened, slot 0 in the low bits
    for (genvar g = 0; g < Q_LENGTH; g++) begin : g_old_m
        assign old_m_vector[g*M_WIDTH +: M_WIDTH] = m_mem[g];
    end

    // head m-part bypass
    // a head modified this cycle already shows its new m-part
    assign head_m = modify_vector[head] ? new_m_vector[head*M_WIDTH +: M_WIDTH]
                                        : m_mem[head];

    // head entry, m-part over n-part
    assign dout = {head_m, n_mem[head]};

endmodule

`default_nettype wire

// File: hw/squash_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "d_rrag_settings.svh"

// squash after a mispredicted branch
// every valid entry younger than kill_tag gets its valid bit cleared
// purely combinational
// the queue applies the result at the next edge
module squash_ctrl
    import d_rrag_pkg::*;
(
    input  logic                                          kill,
    input  tag_t                                          kill_tag,
    input  logic [`D_RRAG_Q_LENGTH*$bits(m_field_t)-1:0] old_m_vector,
    output logic [`D_RRAG_Q_LENGTH-1:0]                   modify_vector,
    output logic [`D_RRAG_Q_LENGTH*$bits(m_field_t)-1:0] new_m_vector
);

    localparam int Q_LENGTH  = `D_RRAG_Q_LENGTH;
    localparam int M_W       = $bits(m_field_t);
    localparam int TAG_W     = $bits(tag_t);
    // valid bit sits above the tag
    localparam int VALID_BIT = TAG_W;
    // ages 1 .. depth-1 count as younger
    localparam int MAX_AGE   = Q_LENGTH - 1;

    for (genvar g = 0; g < Q_LENGTH; g++) begin : g_slot
        // this slot's m-part split up
        m_field_t slot_m;
        tag_t     slot_tag;
        logic     slot_valid;
        // distance from the killing branch modulo 2**TAG_W
        tag_t     age;
        logic     younger;

        assign slot_m     = old_m_vector[g*M_W +: M_W];
        assign slot_tag   = slot_m[TAG_W-1:0];
        assign slot_valid = slot_m[VALID_BIT];

        // wrapping subtract gives the age directly
        assign age = slot_tag - kill_tag;

        // zero is the branch itself and stays alive
        // anything past depth-1 is older and wrapped around
        assign younger = (age != '0) && (age <= tag_t'(MAX_AGE));

        // only touch live entries
        // popped slots still carry their old valid bit
        // a later write replaces them before they are read again
        assign modify_vector[g] = kill && slot_valid && younger;

        // same tag with valid dropped
        assign new_m_vector[g*M_W +: M_W] = {1'b0, slot_tag};
    end

endmodule

`default_nettype wire

// File: hw/rrag_drain.sv
`timescale 1ns/1ns
`default_nettype none

// drain from the queue head into the RrAg output register
// invalid (squashed) heads are popped and dropped, one per cycle
// valid heads move into the register when it is free or being transferred
module rrag_drain
    import d_rrag_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      clr,
    input  logic                                      empty,
    input  logic [$bits(m_field_t)+$bits(payload_t)-1:0] head,
    output logic                                      rd,
    output logic                                      out_valid,
    output tag_t                                      out_tag,
    output payload_t                                  out_payload,
    input  logic                                      out_ready
);

    localparam int P_W   = $bits(payload_t);
    localparam int TAG_W = $bits(tag_t);

    drain_state_t state;

    // head entry split into m-part and payload
    m_field_t head_m;
    payload_t head_payload;
    logic     head_valid;

    logic reg_free;
    logic load;

    assign head_m       = head[P_W +: $bits(m_field_t)];
    assign head_payload = head[P_W-1:0];
    assign head_valid   = head_m[TAG_W];

    // register free now, or emptied by this cycle's transfer
    assign reg_free = (state == DRAIN_EMPTY) || out_ready;

    // valid head goes into the output register
    assign load = !empty && head_valid && reg_free;

    // pop dead heads always, live ones only when they can be taken
    assign rd = !empty && (!head_valid || reg_free);

    assign out_valid = (state == DRAIN_HOLD);

    // output register state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DRAIN_EMPTY;
        end else if (clr) begin
            state <= DRAIN_EMPTY;
        end else if (load) begin
            // reload in the same edge as a transfer
            state <= DRAIN_HOLD;
        end else if (out_ready) begin
            state <= DRAIN_EMPTY;
        end
    end

    // payload register, held under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            out_tag     <= head_m[TAG_W-1:0];
            out_payload <= head_payload;
        end
    end

endmodule

`default_nettype wire

// File: hw/d_rrag_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "d_rrag_settings.svh"

// D to RrAg latch queue
// queue, squash unit and drain stage wired together
module d_rrag_top
    import d_rrag_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_wr,
    input  tag_t     in_tag,
    input  payload_t in_payload,
    output logic     full,
    output logic     empty,
    input  logic     kill,
    input  tag_t     kill_tag,
    input  logic     clr,
    output logic     out_valid,
    input  logic     out_ready,
    output tag_t     out_tag,
    output payload_t out_payload
);

    localparam int Q_LENGTH = `D_RRAG_Q_LENGTH;
    localparam int M_W      = $bits(m_field_t);
    localparam int N_W      = $bits(payload_t);

    // new entry m-part, always written valid
    m_field_t m_din;

    // squash path
    logic [M_W*Q_LENGTH-1:0] old_m_vector;
    logic [M_W*Q_LENGTH-1:0] new_m_vector;
    logic [Q_LENGTH-1:0]     modify_vector;

    // head path
    logic [M_W+N_W-1:0] dout;
    logic               rd;

    assign m_din = {1'b1, in_tag};

    queue_nm #(
        .M_WIDTH  (M_W),
        .N_WIDTH  (N_W),
        .Q_LENGTH (Q_LENGTH)
    ) i_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .m_din         (m_din),
        .n_din         (in_payload),
        .new_m_vector  (new_m_vector),
        .modify_vector (modify_vector),
        .wr            (in_wr),
        .rd            (rd),
        .clr           (clr),
        .full          (full),
        .empty         (empty),
        .old_m_vector  (old_m_vector),
        .dout          (dout)
    );

    squash_ctrl i_squash (
        .kill          (kill),
        .kill_tag      (kill_tag),
        .old_m_vector  (old_m_vector),
        .modify_vector (modify_vector),
        .new_m_vector  (new_m_vector)
    );

    rrag_drain i_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .clr         (clr),
        .empty       (empty),
        .head        (dout),
        .rd          (rd),
        .out_valid   (out_valid),
        .out_tag     (out_tag),
        .out_payload (out_payload),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

// File: sim/tb_d_rrag.sv
`timescale 1ns/1ns
`default_nettype none

`include "d_rrag_settings.svh"

module tb_d_rrag
    import d_rrag_pkg::*;
();

    logic     clk;
    logic     rst_n;
    logic     in_wr;
    tag_t     in_tag;
    payload_t in_payload;
    logic     full;
    logic     empty;
    logic     kill;
    tag_t     kill_tag;
    logic     clr;
    logic     out_valid;
    logic     out_ready;
    tag_t     out_tag;
    payload_t out_payload;

    // reference model, accepted micro-ops not yet delivered and not squashed
    tag_t     model_tag[$];
    payload_t model_pl[$];
    tag_t     next_tag;

    // expected transfer for the coming edge
    logic     exp_any;
    tag_t     exp_tag;
    payload_t exp_payload;

    // DUT outputs captured mid-cycle, current and one cycle back
    logic     seen_valid;
    logic     seen_empty;
    tag_t     seen_tag;
    tag_t     prev_tag;
    payload_t seen_payload;
    payload_t prev_payload;

    d_rrag_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_wr       (in_wr),
        .in_tag      (in_tag),
        .in_payload  (in_payload),
        .full        (full),
        .empty       (empty),
        .kill        (kill),
        .kill_tag    (kill_tag),
        .clr         (clr),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_tag     (out_tag),
        .out_payload (out_payload)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        fail_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    // every transfer is the oldest live micro-op in the model
    a_xfer_known: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> exp_any)
        else fail_run("a micro-op was delivered while none was outstanding");
    a_xfer_tag: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_tag == exp_tag)
        else value_mismatch("out_tag", 32'(seen_tag), 32'(exp_tag));
    a_xfer_payload: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_payload == exp_payload)
        else value_mismatch("out_payload", seen_payload, exp_payload);

    // output register frozen while RrAg stalls
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !clr |=> out_valid)
        else value_mismatch("out_valid", 32'(seen_valid), 32'h1);
    a_hold_tag: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !clr |=> $stable(out_tag))
        else value_mismatch("out_tag", 32'(seen_tag), 32'(prev_tag));
    a_hold_payload: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !clr |=> $stable(out_payload))
        else value_mismatch("out_payload", seen_payload, prev_payload);

    // flush leaves nothing behind
    a_clr_valid: assert property (@(posedge clk) disable iff (!rst_n)
        clr |=> !out_valid)
        else value_mismatch("out_valid", 32'(seen_valid), 32'h0);
    a_clr_empty: assert property (@(posedge clk) disable iff (!rst_n)
        clr |=> empty)
        else value_mismatch("empty", 32'(seen_empty), 32'h1);

    // one cycle, inputs set at the falling edge, model updated for the next rise
    task automatic step(input logic wr, input logic rdy, input logic kl, input tag_t ktag,
                        input logic cl, input payload_t pl);
        tag_t age;
        @(negedge clk);
        in_wr      = wr;
        in_tag     = next_tag;
        in_payload = pl;
        out_ready  = rdy;
        kill       = kl;
        kill_tag   = ktag;
        clr        = cl;
        // outputs hold still until the rising edge
        prev_tag     = seen_tag;
        prev_payload = seen_payload;
        seen_valid   = out_valid;
        seen_empty   = empty;
        seen_tag     = out_tag;
        seen_payload = out_payload;
        exp_any = (model_tag.size() != 0);
        if (exp_any) begin
            exp_tag     = model_tag[0];
            exp_payload = model_pl[0];
        end
        if (out_valid && rdy && exp_any) begin
            void'(model_tag.pop_front());
            void'(model_pl.pop_front());
        end
        if (cl) begin
            model_tag.delete();
            model_pl.delete();
        end else begin
            // younger means age 1 .. depth-1 modulo the tag range
            if (kl) begin
                for (int i = model_tag.size() - 1; i >= 0; i--) begin
                    age = model_tag[i] - ktag;
                    if (age != '0 && age <= tag_t'(`D_RRAG_Q_LENGTH - 1)) begin
                        model_tag.delete(i);
                        model_pl.delete(i);
                    end
                end
            end
            // written after the squash, so never squashed itself
            if (wr && !full) begin
                model_tag.push_back(next_tag);
                model_pl.push_back(pl);
                next_tag = next_tag + 1'b1;
            end
        end
    endtask

    task automatic check_idle();
        assert (out_valid == 1'b0) else value_mismatch("out_valid", 32'(out_valid), 32'h0);
        assert (empty == 1'b1) else value_mismatch("empty", 32'(empty), 32'h1);
        assert (full == 1'b0) else value_mismatch("full", 32'(full), 32'h0);
    endtask

    task automatic drain_all();
        int waited;
        waited = 0;
        while (model_tag.size() != 0 || out_valid || !empty) begin
            if (waited == 200) begin
                fail_run("timeout while draining the queue");
            end
            step(1'b0, 1'b1, 1'b0, '0, 1'b0, '0);
            waited++;
        end
        check_idle();
    endtask

    // RrAg stalled, write until the queue reports full
    task automatic fill_until_full();
        int waited;
        step(1'b0, 1'b0, 1'b0, '0, 1'b1, '0);
        waited = 0;
        while (!full) begin
            if (waited == 20) begin
                fail_run("timeout waiting for full to rise");
            end
            step(1'b1, 1'b0, 1'b0, '0, 1'b0, $urandom);
            waited++;
        end
        // depth in the queue plus one in the output register
        assert (model_tag.size() == `D_RRAG_Q_LENGTH + 1)
            else value_mismatch("held micro-ops", 32'(model_tag.size()),
                                32'(`D_RRAG_Q_LENGTH + 1));
        assert (out_valid == 1'b1) else value_mismatch("out_valid", 32'(out_valid), 32'h1);
        // these writes are dropped
        repeat (4) begin
            step(1'b1, 1'b0, 1'b0, '0, 1'b0, 32'hdead_0000 | $urandom_range(16'hffff, 0));
            assert (full == 1'b1) else value_mismatch("full", 32'(full), 32'h1);
        end
    endtask

    task automatic random_traffic(input int cycles);
        logic wr;
        logic rdy;
        logic kl;
        logic cl;
        tag_t ktag;
        int   idx;
        for (int c = 0; c < cycles; c++) begin
            wr   = ($urandom_range(99, 0) < 65);
            rdy  = ($urandom_range(99, 0) < 55);
            cl   = ($urandom_range(199, 0) == 0);
            kl   = !cl && model_tag.size() != 0 && ($urandom_range(11, 0) == 0);
            ktag = '0;
            // branch is some micro-op still in flight
            if (kl) begin
                idx  = $urandom_range(model_tag.size() - 1, 0);
                ktag = model_tag[idx];
            end
            step(wr, rdy, kl, ktag, cl, $urandom);
        end
    endtask

    initial begin
        void'($urandom(32'h320a_2e54));
        rst_n        = 1'b0;
        in_wr        = 1'b0;
        in_tag       = '0;
        in_payload   = '0;
        kill         = 1'b0;
        kill_tag     = '0;
        clr          = 1'b0;
        out_ready    = 1'b0;
        next_tag     = '0;
        exp_any      = 1'b0;
        exp_tag      = '0;
        exp_payload  = '0;
        seen_valid   = 1'b0;
        seen_empty   = 1'b1;
        seen_tag     = '0;
        prev_tag     = '0;
        seen_payload = '0;
        prev_payload = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_idle();
        random_traffic(800);
        drain_all();
        fill_until_full();
        drain_all();
        // full queue flushed, nothing of it may come out
        fill_until_full();
        step(1'b0, 1'b0, 1'b0, '0, 1'b1, '0);
        drain_all();
        random_traffic(800);
        drain_all();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/d_rrag_pkg.sv
hw/queue_nm.sv
hw/squash_ctrl.sv
hw/rrag_drain.sv
hw/d_rrag_top.sv
sim/tb_d_rrag.sv

// File: run_sim.sh
#!/bin/sh
# build and run the D to RrAg queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_d_rrag -f sources.f -Mdir obj_dir \
    > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_d_rrag > sim.log 2>&1
cat sim.log
# verdict comes from the log
grep -q "Regression failed" sim.log && exit 1 || exit 0
